/* logic/thd_pkg.sv */
package thd_pkg;

    // ====================
    // data widths
    // ====================

    // index of one FFT bin within a frame.
    typedef logic [10:0] bin_t;

    // squared magnitude of one bin.
    typedef logic [31:0] power_t;

    // distortion ratio in Q14.
    typedef logic [31:0] thd_t;

    // input frequency word, the fundamental bin is fre / FRE_PER_BIN.
    typedef logic [10:0] fre_t;

    // ====================
    // constants
    // ====================

    // harmonics 1 to 5 are tracked, the first is the fundamental.
    localparam int NUM_HARM = 5;

    // the harmonic sum is scaled by 2^28 before the divide, so the root lands in Q14.
    localparam int THD_SHIFT = 28;

    // bins 0 to 2 hold DC leakage and never count as a harmonic.
    localparam bin_t MIN_BIN = 11'd3;

endpackage

/* logic/harmonic_peak_hold.sv */
`timescale 1ns/10ps

module harmonic_peak_hold
    import thd_pkg::*;
#(
    parameter int FRE_PER_BIN = 50
) (
    input  logic   clk,
    input  logic   rst,
    input  fre_t   fre,
    input  logic   bin_valid,
    input  bin_t   bin_index,
    input  power_t bin_power,
    input  logic   bin_last,
    input  logic   busy,
    output power_t peak1,
    output power_t peak2,
    output power_t peak3,
    output power_t peak4,
    output power_t peak5,
    output logic   frame_done
);

    bin_t                k_next;
    bin_t                harm_bin [NUM_HARM];
    logic [NUM_HARM-1:0] in_win;
    power_t              peak [NUM_HARM];
    logic                in_frame;
    logic                skip_frame;
    logic                frame_start;
    logic                frame_skip;
    logic                bin_take;

    assign k_next = bin_t'(fre / FRE_PER_BIN);

    // harmonic bins from shifts and adds of the fundamental.
    always_ff @(posedge clk) begin
        harm_bin[0] <= k_next;
        harm_bin[1] <= k_next << 1;
        harm_bin[2] <= k_next + (k_next << 1);
        harm_bin[3] <= k_next << 2;
        harm_bin[4] <= k_next + (k_next << 2);
    end

    // the window is n*k-1 to n*k for the two lowest harmonics
    // and n*k-2 to n*k+1 for the others.
    // compares run one bit wider so that no bound wraps.
    always_comb begin
        logic [$bits(bin_t):0] span;
        logic [$bits(bin_t):0] idx;
        logic [$bits(bin_t):0] hb;
        for (int n = 0; n < NUM_HARM; n++) begin
            span = (n < 2) ? 12'd1 : 12'd2;
            idx = {1'b0, bin_index};
            hb = {1'b0, harm_bin[n]};
            in_win[n] = (idx + span >= hb) && (idx < hb + span) && (bin_index >= MIN_BIN);
        end
    end

    // ====================
    // frame tracking
    // ====================

    assign frame_start = bin_valid && !in_frame && !skip_frame && !busy;
    assign frame_skip  = bin_valid && !in_frame && !skip_frame && busy;
    assign bin_take    = frame_start || (bin_valid && in_frame);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            in_frame   <= 1'b0;
            skip_frame <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= bin_take && bin_last;
            if (frame_start) begin
                in_frame <= !bin_last;
            end else if (bin_take && bin_last) begin
                in_frame <= 1'b0;
            end
            // a frame that opens while busy is dropped up to its last bin.
            if (frame_skip) begin
                skip_frame <= !bin_last;
            end else if (skip_frame && bin_valid && bin_last) begin
                skip_frame <= 1'b0;
            end
        end
    end

    // the first bin of a frame replaces the old peaks.
    always_ff @(posedge clk) begin
        for (int n = 0; n < NUM_HARM; n++) begin
            if (frame_start) begin
                peak[n] <= in_win[n] ? bin_power : '0;
            end else if (bin_take && in_win[n] && (bin_power > peak[n])) begin
                peak[n] <= bin_power;
            end
        end
    end

    assign peak1 = peak[0];
    assign peak2 = peak[1];
    assign peak3 = peak[2];
    assign peak4 = peak[3];
    assign peak5 = peak[4];

endmodule

/* logic/ratio_divider.sv */
`timescale 1ns/10ps

module ratio_divider
    import thd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        div_req,
    input  logic [63:0] dividend,
    input  power_t      divisor,
    output logic        div_ack,
    output logic [63:0] quotient
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0]  state;
    logic [5:0]  step;
    logic [31:0] rem;
    logic [63:0] quo;
    logic [32:0] rem_shift;
    logic        take;

    // with a zero divisor every step takes, and the quotient fills with ones.
    assign rem_shift = {rem, quo[63]};
    assign take      = rem_shift >= {1'b0, divisor};
    assign quotient  = quo;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= ST_IDLE;
            step    <= '0;
            div_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (div_req) begin
                        state <= ST_RUN;
                        step  <= '0;
                    end
                end
                ST_RUN: begin
                    step <= step + 6'd1;
                    if (step == 6'd63) begin
                        state   <= ST_ACK;
                        div_ack <= 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!div_req) begin
                        state   <= ST_IDLE;
                        div_ack <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one quotient bit per cycle, the dividend shifts out as the quotient shifts in.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && div_req) begin
            rem <= '0;
            quo <= dividend;
        end else if (state == ST_RUN) begin
            rem <= take ? rem_shift[31:0] - divisor : rem_shift[31:0];
            quo <= {quo[62:0], take};
        end
    end

endmodule

/* logic/isqrt_unit.sv */
`timescale 1ns/10ps

module isqrt_unit
    import thd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sqrt_req,
    input  logic [63:0] radicand,
    output logic        sqrt_ack,
    output thd_t        root
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0]  state;
    logic [4:0]  step;
    logic [63:0] rad_sh;
    logic [33:0] rem;
    thd_t        root_r;
    logic [35:0] rem_next;
    logic [35:0] trial;
    logic        take;

    // bring down the next two radicand bits and try the digit 1.
    assign rem_next = {rem, rad_sh[63:62]};
    assign trial    = {2'b00, root_r, 2'b01};
    assign take     = rem_next >= trial;
    assign root     = root_r;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= ST_IDLE;
            step     <= '0;
            sqrt_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sqrt_req) begin
                        state <= ST_RUN;
                        step  <= '0;
                    end
                end
                ST_RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state    <= ST_ACK;
                        sqrt_ack <= 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!sqrt_req) begin
                        state    <= ST_IDLE;
                        sqrt_ack <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && sqrt_req) begin
            rad_sh <= radicand;
            rem    <= '0;
            root_r <= '0;
        end else if (state == ST_RUN) begin
            rad_sh <= rad_sh << 2;
            rem    <= take ? 34'(rem_next - trial) : rem_next[33:0];
            root_r <= {root_r[30:0], take};
        end
    end

endmodule

/* logic/thd_controller.sv */
`timescale 1ns/10ps

module thd_controller
    import thd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  power_t      peak1,
    input  power_t      peak2,
    input  power_t      peak3,
    input  power_t      peak4,
    input  power_t      peak5,
    input  logic        frame_done,
    input  logic        div_ack,
    input  logic [63:0] quotient,
    input  logic        sqrt_ack,
    input  thd_t        root,
    input  logic        result_ack,
    output logic        busy,
    output logic        div_req,
    output logic [63:0] dividend,
    output power_t      divisor,
    output logic        sqrt_req,
    output logic [63:0] radicand,
    output logic        result_req,
    output thd_t        thd,
    output power_t      h1,
    output power_t      h2,
    output power_t      h3,
    output power_t      h4,
    output power_t      h5
);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_DIV      = 3'd1;
    localparam logic [2:0] ST_DIV_REL  = 3'd2;
    localparam logic [2:0] ST_ROOT     = 3'd3;
    localparam logic [2:0] ST_ROOT_REL = 3'd4;
    localparam logic [2:0] ST_REP      = 3'd5;
    localparam logic [2:0] ST_REP_REL  = 3'd6;

    logic [2:0]  state;
    logic [33:0] harm_sum;

    // four 32-bit powers need two extra bits.
    assign harm_sum = 34'(h2) + 34'(h3) + 34'(h4) + 34'(h5);
    assign dividend = 64'(harm_sum) << THD_SHIFT;
    assign divisor  = h1;

    // ====================
    // sequencer
    // ====================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            div_req    <= 1'b0;
            sqrt_req   <= 1'b0;
            result_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_done) begin
                        state   <= ST_DIV;
                        busy    <= 1'b1;
                        div_req <= 1'b1;
                    end
                end
                ST_DIV: begin
                    if (div_ack) begin
                        state   <= ST_DIV_REL;
                        div_req <= 1'b0;
                    end
                end
                ST_DIV_REL: begin
                    if (!div_ack) begin
                        state    <= ST_ROOT;
                        sqrt_req <= 1'b1;
                    end
                end
                ST_ROOT: begin
                    if (sqrt_ack) begin
                        state    <= ST_ROOT_REL;
                        sqrt_req <= 1'b0;
                    end
                end
                ST_ROOT_REL: begin
                    if (!sqrt_ack) begin
                        state      <= ST_REP;
                        result_req <= 1'b1;
                    end
                end
                ST_REP: begin
                    if (result_ack) begin
                        state      <= ST_REP_REL;
                        result_req <= 1'b0;
                    end
                end
                ST_REP_REL: begin
                    // new frames are accepted again once the ack is gone.
                    if (!result_ack) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // results are taken while the responder holds ack high.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && frame_done) begin
            h1 <= peak1;
            h2 <= peak2;
            h3 <= peak3;
            h4 <= peak4;
            h5 <= peak5;
        end
        if (state == ST_DIV && div_ack) begin
            radicand <= quotient;
        end
        if (state == ST_ROOT && sqrt_ack) begin
            thd <= root;
        end
    end

endmodule

/* logic/thd_analyzer.sv */
`timescale 1ns/10ps

module thd_analyzer
    import thd_pkg::*;
#(
    parameter int FRE_PER_BIN = 50
) (
    input  logic   clk,
    input  logic   rst,
    input  fre_t   fre,
    input  logic   bin_valid,
    input  bin_t   bin_index,
    input  power_t bin_power,
    input  logic   bin_last,
    output logic   result_req,
    input  logic   result_ack,
    output thd_t   thd,
    output power_t h1,
    output power_t h2,
    output power_t h3,
    output power_t h4,
    output power_t h5
);

    power_t      peak1;
    power_t      peak2;
    power_t      peak3;
    power_t      peak4;
    power_t      peak5;
    logic        frame_done;
    logic        busy;
    logic        div_req;
    logic        div_ack;
    logic [63:0] dividend;
    power_t      divisor;
    logic [63:0] quotient;
    logic        sqrt_req;
    logic        sqrt_ack;
    logic [63:0] radicand;
    thd_t        root;

    harmonic_peak_hold #(
        .FRE_PER_BIN (FRE_PER_BIN)
    ) u_peak_hold (
        .clk        (clk),
        .rst        (rst),
        .fre        (fre),
        .bin_valid  (bin_valid),
        .bin_index  (bin_index),
        .bin_power  (bin_power),
        .bin_last   (bin_last),
        .busy       (busy),
        .peak1      (peak1),
        .peak2      (peak2),
        .peak3      (peak3),
        .peak4      (peak4),
        .peak5      (peak5),
        .frame_done (frame_done)
    );

    ratio_divider u_divider (
        .clk      (clk),
        .rst      (rst),
        .div_req  (div_req),
        .dividend (dividend),
        .divisor  (divisor),
        .div_ack  (div_ack),
        .quotient (quotient)
    );

    isqrt_unit u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .sqrt_req (sqrt_req),
        .radicand (radicand),
        .sqrt_ack (sqrt_ack),
        .root     (root)
    );

    thd_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .peak1      (peak1),
        .peak2      (peak2),
        .peak3      (peak3),
        .peak4      (peak4),
        .peak5      (peak5),
        .frame_done (frame_done),
        .div_ack    (div_ack),
        .quotient   (quotient),
        .sqrt_ack   (sqrt_ack),
        .root       (root),
        .result_ack (result_ack),
        .busy       (busy),
        .div_req    (div_req),
        .dividend   (dividend),
        .divisor    (divisor),
        .sqrt_req   (sqrt_req),
        .radicand   (radicand),
        .result_req (result_req),
        .thd        (thd),
        .h1         (h1),
        .h2         (h2),
        .h3         (h3),
        .h4         (h4),
        .h5         (h5)
    );

endmodule

/* tests/thd_controller_assert.sv */
`timescale 1ns/10ps

module thd_controller_assert
    import thd_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   busy,
    input logic   div_req,
    input logic   div_ack,
    input logic   sqrt_req,
    input logic   sqrt_ack,
    input logic   result_req,
    input logic   result_ack,
    input thd_t   thd,
    input power_t h1,
    input power_t h2,
    input power_t h3,
    input power_t h4,
    input power_t h5
);

    // a request is held until its responder acknowledges.
    div_req_held: assert property (@(posedge clk) disable iff (!rst)
        div_req && !div_ack |=> div_req)
        else $error("div_req dropped before div_ack");

    sqrt_req_held: assert property (@(posedge clk) disable iff (!rst)
        sqrt_req && !sqrt_ack |=> sqrt_req)
        else $error("sqrt_req dropped before sqrt_ack");

    result_req_held: assert property (@(posedge clk) disable iff (!rst)
        result_req && !result_ack |=> result_req)
        else $error("result_req dropped before result_ack");

    result_data_stable: assert property (@(posedge clk) disable iff (!rst)
        result_req |=> !result_req || $stable({thd, h1, h2, h3, h4, h5}))
        else $error("result data changed while result_req was high");

    busy_covers_req: assert property (@(posedge clk) disable iff (!rst)
        (div_req || sqrt_req || result_req) |-> busy)
        else $error("a request was high while busy was low");

endmodule

bind thd_controller thd_controller_assert u_ctrl_assert (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .div_req    (div_req),
    .div_ack    (div_ack),
    .sqrt_req   (sqrt_req),
    .sqrt_ack   (sqrt_ack),
    .result_req (result_req),
    .result_ack (result_ack),
    .thd        (thd),
    .h1         (h1),
    .h2         (h2),
    .h3         (h3),
    .h4         (h4),
    .h5         (h5)
);

/* tests/thd_analyzer_tb.sv */
`timescale 1ns/10ps

module thd_analyzer_tb
    import thd_pkg::*;
#(
    parameter int FRE_PER_BIN = 50
);

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int FRAME_LEN    = 512;
    localparam int NUM_CASES    = 9;
    localparam int CASE_WORDS   = NUM_HARM + 2;
    localparam int HOLD_CASE    = 3;
    localparam int HOLD_CYCLES  = 300;
    localparam int REQ_WAIT     = 400;
    localparam int QUIET_CYCLES = 150;
    localparam int WATCHDOG     = (NUM_CASES + 2) * 700;

    logic   clk;
    logic   rst;
    fre_t   fre;
    logic   bin_valid;
    bin_t   bin_index;
    power_t bin_power;
    logic   bin_last;
    logic   result_req;
    logic   result_ack;
    thd_t   thd;
    power_t h1;
    power_t h2;
    power_t h3;
    power_t h4;
    power_t h5;

    logic [31:0] case_mem [NUM_CASES * CASE_WORDS];
    logic [31:0] rng_state;
    fre_t        case_fre;
    power_t      exp_pwr [NUM_HARM];
    power_t      frame_pwr [NUM_HARM];
    thd_t        exp_thd;
    logic        expect_idle;
    logic        hold_active;
    int          value_errors;
    int          other_errors;

    thd_analyzer #(
        .FRE_PER_BIN (FRE_PER_BIN)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .fre        (fre),
        .bin_valid  (bin_valid),
        .bin_index  (bin_index),
        .bin_power  (bin_power),
        .bin_last   (bin_last),
        .result_req (result_req),
        .result_ack (result_ack),
        .thd        (thd),
        .h1         (h1),
        .h2         (h2),
        .h3         (h3),
        .h4         (h4),
        .h5         (h5)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG);
        $display("Something failed");
        $finish;
    end

    // ====================
    // checks
    // ====================

    task automatic check_power(input string name, input power_t exp, input power_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_thd(input string name, input thd_t exp, input thd_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        check_thd("thd", exp_thd, thd);
        check_power("h1", exp_pwr[0], h1);
        check_power("h2", exp_pwr[1], h2);
        check_power("h3", exp_pwr[2], h3);
        check_power("h4", exp_pwr[3], h4);
        check_power("h5", exp_pwr[4], h5);
    endtask

    // outputs only move on the rising edge, so they are settled here.
    task automatic step_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        if (expect_idle) begin
            check_bit("result_req", 1'b0, result_req);
        end
        if (hold_active) begin
            check_bit("result_req", 1'b1, result_req);
            check_outputs();
        end
    endtask

    // ====================
    // stimulus
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // n counts from 0 for the fundamental.
    function automatic logic in_window(input int bin, input int hb, input int n);
        int lo;
        int hi;
        lo = (n < 2) ? hb - 1 : hb - 2;
        hi = (n < 2) ? hb : hb + 1;
        return (bin >= int'(MIN_BIN)) && (bin >= lo) && (bin <= hi);
    endfunction

    task automatic load_case(input int c);
        int base;
        base = c * CASE_WORDS;
        case_fre = fre_t'(case_mem[base]);
        for (int n = 0; n < NUM_HARM; n++) begin
            exp_pwr[n]   = case_mem[base + 1 + n];
            frame_pwr[n] = case_mem[base + 1 + n];
        end
        // a missing fundamental saturates the ratio.
        exp_thd = (exp_pwr[0] == '0) ? '1 : case_mem[base + CASE_WORDS - 1];
    endtask

    task automatic send_frame(input logic with_last);
        int     k;
        power_t pwr;
        k = int'(case_fre) / FRE_PER_BIN;
        fre = case_fre;
        repeat (2) step_cycle();
        for (int b = 0; b < FRAME_LEN; b++) begin
            rng_state = xorshift32(rng_state);
            pwr = rng_state & 32'h0000_000f;
            for (int n = 0; n < NUM_HARM; n++) begin
                // windows of an absent harmonic stay silent so that its peak reads zero.
                if (frame_pwr[n] == '0 && in_window(b, (n + 1) * k, n)) begin
                    pwr = '0;
                end
                if (b == (n + 1) * k) begin
                    pwr = frame_pwr[n];
                end
            end
            bin_valid = 1'b1;
            bin_index = bin_t'(b);
            bin_power = pwr;
            bin_last  = with_last && (b == FRAME_LEN - 1);
            step_cycle();
        end
        bin_valid = 1'b0;
        bin_last  = 1'b0;
    endtask

    task automatic wait_req(input logic level, output logic seen);
        int n;
        n = 0;
        @(negedge clk);
        while (result_req !== level && n < REQ_WAIT) begin
            @(negedge clk);
            n++;
        end
        seen = (result_req === level);
    endtask

    task automatic release_result(input int c);
        logic seen;
        result_ack = 1'b1;
        wait_req(1'b0, seen);
        if (!seen) begin
            $display("case %0d kept result_req high after result_ack", c);
            other_errors++;
        end
        step_cycle();
        result_ack = 1'b0;
        repeat (2) step_cycle();
    endtask

    task automatic collect_result(input int c);
        logic seen;
        wait_req(1'b1, seen);
        if (!seen) begin
            $display("case %0d gave no result_req within %0d cycles", c, REQ_WAIT);
            other_errors++;
        end else begin
            check_outputs();
            step_cycle();
            if (c == HOLD_CASE) begin
                // this frame opens while the result waits and ends after busy falls.
                // it is dropped whole, so its tail must not produce a result.
                hold_active = 1'b1;
                for (int n = 0; n < NUM_HARM; n++) begin
                    frame_pwr[n] = 32'h0000_7777;
                end
                fork
                    send_frame(1'b1);
                    begin
                        repeat (HOLD_CYCLES) @(posedge clk);
                        #(DRIVE_DELAY);
                        hold_active = 1'b0;
                        release_result(c);
                        expect_idle = 1'b1;
                    end
                join
                repeat (QUIET_CYCLES) step_cycle();
                expect_idle = 1'b0;
            end else begin
                release_result(c);
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        rst          = 1'b0;
        fre          = '0;
        bin_valid    = 1'b0;
        bin_index    = '0;
        bin_power    = '0;
        bin_last     = 1'b0;
        result_ack   = 1'b0;
        rng_state    = 32'h1672;
        value_errors = 0;
        other_errors = 0;
        expect_idle  = 1'b0;
        hold_active  = 1'b0;
        for (int i = 0; i < NUM_CASES * CASE_WORDS; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("tests/thd_cases.txt", case_mem);
        if (case_mem[(NUM_CASES - 1) * CASE_WORDS] == '1) begin
            $display("case file tests/thd_cases.txt holds fewer than %0d cases", NUM_CASES);
            other_errors++;
        end
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;

        // the first case joins this open frame, so its bins are kept silent.
        expect_idle = 1'b1;
        load_case(0);
        for (int n = 0; n < NUM_HARM; n++) begin
            frame_pwr[n] = '0;
        end
        send_frame(1'b0);
        repeat (QUIET_CYCLES) step_cycle();
        expect_idle = 1'b0;

        for (int c = 0; c < NUM_CASES; c++) begin
            load_case(c);
            send_frame(1'b1);
            collect_result(c);
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tests/thd_cases.txt */
// columns: fre p1 p2 p3 p4 p5 thd, all hex, the fundamental bin is fre / 50.
// thd = floor(sqrt(floor((p2+p3+p4+p5) * 2^28 / p1))), all ones when p1 is zero.
096 00010000 00000000 00000000 00000000 00000000 00000000
0fa 00100000 00010000 00000000 00000000 00000000 00001000
190 00000000 00000400 00000300 00000000 00000000 ffffffff
7d0 00000100 00000100 00000100 00000100 00000100 00008000
208 00400000 00001000 00002000 00004000 00008000 000007be
177 00000300 00000100 00000000 00000000 00000000 000024f3
3e8 00010000 00000000 00004000 00000000 00000000 00002000
672 01000000 00040000 00040000 00040000 00040000 00001000
12c 00000100 ffffffff ffffffff ffffffff ffffffff 07ffffff

/* project.f */
logic/thd_pkg.sv
logic/harmonic_peak_hold.sv
logic/ratio_divider.sv
logic/isqrt_unit.sv
logic/thd_controller.sv
logic/thd_analyzer.sv
tests/thd_controller_assert.sv
tests/thd_analyzer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = thd_analyzer_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
